// File: logic/player_pkg.sv
package player_pkg;

  // ==================================================
  // Flash geometry
  // ==================================================

  // Word-addressed flash, 32-bit data
  localparam int FLASH_ADDR_W = 23;
  localparam int FLASH_DATA_W = 32;

  typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;
  typedef logic [FLASH_DATA_W-1:0] flash_word_t;

  // ==================================================
  // Audio samples and song length
  // ==================================================

  localparam int SAMPLE_W = 8;

  // Codec expects signed samples
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Last word of the song image in flash
  localparam flash_addr_t LAST_WORD_DEFAULT = 23'h7FFFF;

endpackage

// File: logic/control_pkg.sv
package control_pkg;

  // ==================================================
  // Keyboard commands
  // ==================================================

  typedef logic [7:0] scan_code_t;

  // PS/2 set 2 make codes
  localparam scan_code_t SCAN_PLAY     = 8'h24;
  localparam scan_code_t SCAN_PAUSE    = 8'h23;
  localparam scan_code_t SCAN_FORWARD  = 8'h2B;
  localparam scan_code_t SCAN_BACKWARD = 8'h32;
  localparam scan_code_t SCAN_RESTART  = 8'h2D;

  // ==================================================
  // Push keys and playback speed
  // ==================================================

  // Bit positions in key_n
  localparam int KEY_FASTER  = 0;
  localparam int KEY_SLOWER  = 1;
  localparam int KEY_DEFAULT = 2;

  localparam int PERIOD_W = 16;
  typedef logic [PERIOD_W-1:0] period_t;

  // 50 MHz / 2268 is about 22.05 kHz
  localparam period_t PERIOD_DEFAULT = 16'd2268;
  localparam period_t PERIOD_STEP    = 16'd100;
  localparam period_t PERIOD_MIN     = 16'd268;
  localparam period_t PERIOD_MAX     = 16'd8268;

  // 100 ms between steps of a held key
  localparam int REPEAT_CYCLES_DEFAULT = 5_000_000;

endpackage

// File: logic/kbd_cmd_decoder.sv
`timescale 1ns/10ps

module kbd_cmd_decoder (
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  control_pkg::scan_code_t scan_code,
  input  logic                    scan_valid,
  output logic                    play,
  output logic                    forward,
  output logic                    restart
);

  // Play and direction are levels, restart is a single-cycle strobe
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      play    <= 1'b0;
      forward <= 1'b1;
      restart <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (scan_valid)
      begin
        case (scan_code)
          control_pkg::SCAN_PLAY:     play    <= 1'b1;
          control_pkg::SCAN_PAUSE:    play    <= 1'b0;
          control_pkg::SCAN_FORWARD:  forward <= 1'b1;
          control_pkg::SCAN_BACKWARD: forward <= 1'b0;
          control_pkg::SCAN_RESTART:  restart <= 1'b1;
          // Anything else is ignored
          default:
          begin
          end
        endcase
      end
    end
  end

endmodule

// File: logic/speed_control.sv
`timescale 1ns/10ps

module speed_control #(
  parameter int repeat_cycles = control_pkg::REPEAT_CYCLES_DEFAULT
) (
  input  logic                 CLK_50M,
  input  logic                 rst,
  input  logic [2:0]           key_n,
  output control_pkg::period_t sample_period
);

  localparam int REP_W = (repeat_cycles > 1) ? $clog2(repeat_cycles) : 1;

  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic [2:0]       key_held;
  logic [REP_W-1:0] rep_cnt;
  logic             rep_wrap;
  logic             step_down;
  logic             step_up;

  // ==================================================
  // Key synchronizer
  // ==================================================

  // Released keys read high
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      key_meta <= 3'b111;
      key_sync <= 3'b111;
    end
    else
    begin
      key_meta <= key_n;
      key_sync <= key_meta;
    end
  end

  assign key_held = ~key_sync;

  // ==================================================
  // Repeat timer
  // ==================================================

  // Free-running, one wrap per repeat interval
  assign rep_wrap = (rep_cnt == REP_W'(repeat_cycles - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (rst || rep_wrap)
      rep_cnt <= '0;
    else
      rep_cnt <= rep_cnt + 1'b1;
  end

  // Both step keys held cancel out
  assign step_down = rep_wrap && key_held[control_pkg::KEY_FASTER]
                     && !key_held[control_pkg::KEY_SLOWER];
  assign step_up   = rep_wrap && key_held[control_pkg::KEY_SLOWER]
                     && !key_held[control_pkg::KEY_FASTER];

  // ==================================================
  // Period register
  // ==================================================

  always_ff @(posedge CLK_50M)
  begin
    if (rst || key_held[control_pkg::KEY_DEFAULT])
      sample_period <= control_pkg::PERIOD_DEFAULT;
    else if (step_down)
    begin
      // Shorter period means faster playback
      if (sample_period < control_pkg::PERIOD_MIN + control_pkg::PERIOD_STEP)
        sample_period <= control_pkg::PERIOD_MIN;
      else
        sample_period <= sample_period - control_pkg::PERIOD_STEP;
    end
    else if (step_up)
    begin
      if (sample_period > control_pkg::PERIOD_MAX - control_pkg::PERIOD_STEP)
        sample_period <= control_pkg::PERIOD_MAX;
      else
        sample_period <= sample_period + control_pkg::PERIOD_STEP;
    end
  end

endmodule

// File: logic/sample_tick_gen.sv
`timescale 1ns/10ps

module sample_tick_gen (
  input  logic                 CLK_50M,
  input  logic                 rst,
  input  control_pkg::period_t sample_period,
  output logic                 tick
);

  control_pkg::period_t count;

  // Counts sample_period-1 down to 0, so one tick per period.
  // The period is sampled only on reload.
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      count <= sample_period - 1'b1;
      tick  <= 1'b0;
    end
    else if (count == '0)
    begin
      count <= sample_period - 1'b1;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

// File: logic/flash_reader.sv
`timescale 1ns/10ps

module flash_reader #(
  parameter player_pkg::flash_addr_t last_word = player_pkg::LAST_WORD_DEFAULT
) (
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  logic                    tick,
  input  logic                    play,
  input  logic                    forward,
  input  logic                    restart,
  output logic                    flash_read,
  output player_pkg::flash_addr_t flash_address,
  input  logic                    flash_waitrequest,
  input  player_pkg::flash_word_t flash_readdata,
  input  logic                    flash_readdatavalid,
  output player_pkg::sample_t     audio_sample,
  output logic                    sample_valid
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_WAIT_DATA
  } state_t;

  state_t                  state;
  player_pkg::flash_addr_t addr;
  player_pkg::flash_addr_t addr_next;
  player_pkg::flash_word_t word_buf;
  logic                    half_pending;
  logic                    word_fwd;
  logic                    restart_pend;

  // Address only moves in idle, so it holds through waitrequest
  assign flash_read    = (state == ST_REQUEST);
  assign flash_address = addr;

  // Step uses the direction the buffered word was fetched with
  always_comb
  begin
    if (word_fwd)
      addr_next = (addr == last_word) ? '0 : addr + 1'b1;
    else
      addr_next = (addr == '0) ? last_word : addr - 1'b1;
  end

  // ==================================================
  // Fetch FSM and sample output
  // ==================================================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state        <= ST_IDLE;
      addr         <= '0;
      half_pending <= 1'b0;
      word_fwd     <= 1'b1;
      restart_pend <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      // Restart during a fetch is applied once back in idle
      if (restart)
        restart_pend <= 1'b1;

      case (state)
        ST_IDLE:
        begin
          if (restart || restart_pend)
          begin
            addr         <= forward ? '0 : last_word;
            half_pending <= 1'b0;
            restart_pend <= 1'b0;
          end
          else if (tick && play)
          begin
            if (half_pending)
            begin
              // Second half of the word, then move on
              audio_sample <= word_fwd ? word_buf[31:24] : word_buf[15:8];
              sample_valid <= 1'b1;
              half_pending <= 1'b0;
              addr         <= addr_next;
            end
            else
            begin
              word_fwd <= forward;
              state    <= ST_REQUEST;
            end
          end
        end

        ST_REQUEST:
        begin
          if (!flash_waitrequest)
            state <= ST_WAIT_DATA;
        end

        // Ticks arriving here are dropped
        ST_WAIT_DATA:
        begin
          if (flash_readdatavalid)
          begin
            state <= ST_IDLE;
            if (!(restart || restart_pend))
            begin
              word_buf     <= flash_readdata;
              audio_sample <= word_fwd ? flash_readdata[15:8] : flash_readdata[31:24];
              sample_valid <= 1'b1;
              half_pending <= 1'b1;
            end
          end
        end

        default:
          state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: logic/ipod_top.sv
`timescale 1ns/10ps

module ipod_top #(
  parameter int                      repeat_cycles = control_pkg::REPEAT_CYCLES_DEFAULT,
  parameter player_pkg::flash_addr_t last_word     = player_pkg::LAST_WORD_DEFAULT
) (
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  control_pkg::scan_code_t scan_code,
  input  logic                    scan_valid,
  input  logic [2:0]              key_n,
  output logic                    flash_read,
  output player_pkg::flash_addr_t flash_address,
  input  logic                    flash_waitrequest,
  input  player_pkg::flash_word_t flash_readdata,
  input  logic                    flash_readdatavalid,
  output player_pkg::sample_t     audio_sample,
  output logic                    sample_valid,
  output control_pkg::period_t    sample_period,
  output logic                    playing,
  output logic                    forward
);

  logic restart;
  logic tick;

  // ==================================================
  // Controls
  // ==================================================

  kbd_cmd_decoder kbd_cmd_decoder_i (
    .CLK_50M    (CLK_50M),
    .rst        (rst),
    .scan_code  (scan_code),
    .scan_valid (scan_valid),
    .play       (playing),
    .forward    (forward),
    .restart    (restart)
  );

  speed_control #(
    .repeat_cycles (repeat_cycles)
  ) speed_control_i (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .key_n         (key_n),
    .sample_period (sample_period)
  );

  // ==================================================
  // Datapath
  // ==================================================

  sample_tick_gen sample_tick_gen_i (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .sample_period (sample_period),
    .tick          (tick)
  );

  flash_reader #(
    .last_word (last_word)
  ) flash_reader_i (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .tick                (tick),
    .play                (playing),
    .forward             (forward),
    .restart             (restart),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_valid        (sample_valid)
  );

endmodule

// File: dv/flash_model.sv
`timescale 1ns/10ps

module flash_model (
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  logic                    flash_read,
  input  player_pkg::flash_addr_t flash_address,
  output logic                    flash_waitrequest,
  output player_pkg::flash_word_t flash_readdata,
  output logic                    flash_readdatavalid
);

  logic [31:0]             rng;
  logic [1:0]              wait_left;
  logic [2:0]              lat_left;
  player_pkg::flash_addr_t addr_q;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Samples sit in bytes 1 and 3, upper address bits fill bytes 0 and 2
  function automatic player_pkg::flash_word_t word_at(input player_pkg::flash_addr_t a);
    return {a[7:0] + 8'h11, a[15:8], a[7:0] ^ 8'h5A, 1'b0, a[22:16]};
  endfunction

  // Wait states count down only while a read is presented
  assign flash_waitrequest = (wait_left != 2'd0);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      rng                 <= 32'd67677;
      wait_left           <= '0;
      lat_left            <= '0;
      addr_q              <= '0;
      flash_readdata      <= '0;
      flash_readdatavalid <= 1'b0;
    end
    else
    begin
      rng                 <= xorshift32(rng);
      flash_readdatavalid <= 1'b0;
      if (lat_left != 3'd0)
      begin
        lat_left <= lat_left - 1'b1;
        if (lat_left == 3'd1)
        begin
          flash_readdata      <= word_at(addr_q);
          flash_readdatavalid <= 1'b1;
        end
      end
      if (flash_read && wait_left != 2'd0)
        wait_left <= wait_left - 1'b1;
      else if (flash_read)
      begin
        // Accepted, draw the data latency and the next read's wait states
        addr_q    <= flash_address;
        lat_left  <= 3'd1 + rng[4:3];
        wait_left <= rng[1:0];
      end
    end
  end

endmodule

// File: dv/ipod_properties.sv
`timescale 1ns/10ps

module ipod_properties #(
  parameter player_pkg::flash_addr_t last_word = player_pkg::LAST_WORD_DEFAULT
) (
  input logic                    CLK_50M,
  input logic                    rst,
  input control_pkg::scan_code_t scan_code,
  input logic                    scan_valid,
  input logic [2:0]              key_n,
  input logic                    tick,
  input logic                    restart,
  input logic                    playing,
  input logic                    forward,
  input logic                    flash_read,
  input player_pkg::flash_addr_t flash_address,
  input logic                    flash_waitrequest,
  input logic                    flash_readdatavalid,
  input player_pkg::sample_t     audio_sample,
  input logic                    sample_valid,
  input control_pkg::period_t    sample_period
);

  // First half trails its tick by up to 9 cycles of fetch
  // and the second half then comes that much early
  localparam int GAP_SLACK = 9;

  int                      fail_count = 0;
  int                      gap;
  logic                    sv_seen;
  logic                    in_flight;
  logic                    tick_play_q;
  logic                    tick_fwd;
  logic                    rdv_q;
  logic                    req_fwd;
  player_pkg::flash_addr_t req_addr;
  player_pkg::flash_addr_t exp_addr;
  logic [7:0]              exp_sample;

  function automatic player_pkg::flash_addr_t step_addr(
    input player_pkg::flash_addr_t a,
    input logic                    fwd
  );
    if (fwd)
      return (a == last_word) ? '0 : a + 1'b1;
    return (a == '0) ? last_word : a - 1'b1;
  endfunction

  // ==================================================
  // Reference state
  // ==================================================

  // Byte 1 first when forward, byte 3 first when backward
  assign exp_sample = (rdv_q == req_fwd) ? (req_addr[7:0] ^ 8'h5A) : (req_addr[7:0] + 8'h11);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      in_flight   <= 1'b0;
      tick_play_q <= 1'b0;
      tick_fwd    <= 1'b1;
      rdv_q       <= 1'b0;
      req_fwd     <= 1'b1;
      req_addr    <= '0;
      exp_addr    <= '0;
      gap         <= 0;
      sv_seen     <= 1'b0;
    end
    else
    begin
      tick_play_q <= tick && playing;
      rdv_q       <= flash_readdatavalid;
      if (tick && playing)
        tick_fwd <= forward;
      if (flash_read && !flash_waitrequest)
      begin
        in_flight <= 1'b1;
        req_addr  <= flash_address;
        req_fwd   <= tick_fwd;
      end
      else if (flash_readdatavalid)
        in_flight <= 1'b0;
      // Word address moves after its second half, or jumps on restart
      if (restart)
        exp_addr <= forward ? '0 : last_word;
      else if (sample_valid && !rdv_q)
        exp_addr <= step_addr(req_addr, req_fwd);
      if (sample_valid)
      begin
        gap     <= 1;
        sv_seen <= 1'b1;
      end
      else if (gap < 1_000_000)
        gap <= gap + 1;
    end
  end

  // ==================================================
  // Player rules
  // ==================================================

  a_reset: assert property (@(posedge CLK_50M) disable iff (rst)
      $fell(rst) |-> !playing && forward && !sample_valid && !flash_read
                     && sample_period == control_pkg::PERIOD_DEFAULT)
    else
    begin
      fail_count++;
      $error("ERROR %0t: state after reset is wrong", $time);
    end

  // Only the matching command code moves a level
  a_levels: assert property (@(posedge CLK_50M) disable iff (rst)
      (!$changed(playing)
       || $past(scan_valid)
          && $past(scan_code) == (playing ? control_pkg::SCAN_PLAY
                                          : control_pkg::SCAN_PAUSE))
      && (!$changed(forward)
          || $past(scan_valid)
             && $past(scan_code) == (forward ? control_pkg::SCAN_FORWARD
                                             : control_pkg::SCAN_BACKWARD)))
    else
    begin
      fail_count++;
      $error("ERROR %0t: play or direction changed without its scan code", $time);
    end

  a_source: assert property (@(posedge CLK_50M) disable iff (rst)
      sample_valid |-> rdv_q || tick_play_q)
    else
    begin
      fail_count++;
      $error("ERROR %0t: sample without readdatavalid or tick in play", $time);
    end

  a_request: assert property (@(posedge CLK_50M) disable iff (rst)
      $rose(flash_read) |-> tick_play_q && flash_address == exp_addr)
    else
    begin
      fail_count++;
      $error("ERROR %0t: read at %0h, expected %0h after a tick in play", $time,
             $sampled(flash_address), $sampled(exp_addr));
    end

  a_hold: assert property (@(posedge CLK_50M) disable iff (rst)
      flash_read && flash_waitrequest |=> flash_read && $stable(flash_address))
    else
    begin
      fail_count++;
      $error("ERROR %0t: read request changed during waitrequest", $time);
    end

  a_single: assert property (@(posedge CLK_50M) disable iff (rst)
      in_flight |-> !flash_read)
    else
    begin
      fail_count++;
      $error("ERROR %0t: second read before readdatavalid", $time);
    end

  a_sample: assert property (@(posedge CLK_50M) disable iff (rst)
      sample_valid |-> audio_sample == exp_sample)
    else
    begin
      fail_count++;
      $error("ERROR %0t: sample %0h, expected %0h", $time,
             $sampled(audio_sample), $sampled(exp_sample));
    end

  a_period: assert property (@(posedge CLK_50M) disable iff (rst)
      sample_period >= control_pkg::PERIOD_MIN && sample_period <= control_pkg::PERIOD_MAX
      && (!$changed(sample_period)
          || sample_period == $past(sample_period) - control_pkg::PERIOD_STEP
          || sample_period == $past(sample_period) + control_pkg::PERIOD_STEP
          || sample_period == control_pkg::PERIOD_DEFAULT))
    else
    begin
      fail_count++;
      $error("ERROR %0t: sample period moved to %0d", $time, $sampled(sample_period));
    end

  a_default: assert property (@(posedge CLK_50M) disable iff (rst)
      !key_n[control_pkg::KEY_DEFAULT] [*3] |=> sample_period == control_pkg::PERIOD_DEFAULT)
    else
    begin
      fail_count++;
      $error("ERROR %0t: default key did not restore the period", $time);
    end

  // A first half ends a full period plus the fetch after the previous sample
  a_gap: assert property (@(posedge CLK_50M) disable iff (rst)
      sample_valid && sv_seen |-> gap + (rdv_q ? 0 : GAP_SLACK) >= sample_period)
    else
    begin
      fail_count++;
      $error("ERROR %0t: samples only %0d cycles apart", $time, $sampled(gap));
    end

endmodule

// File: dv/ipod_tb.sv
`timescale 1ns/10ps

module ipod_tb;

  localparam int SAMPLE_LIMIT = control_pkg::PERIOD_DEFAULT + 64;
  localparam int KEY_LIMIT    = 4000;

  logic                    CLK_50M;
  logic                    rst;
  control_pkg::scan_code_t scan_code;
  logic                    scan_valid;
  logic [2:0]              key_n;
  logic                    flash_read;
  player_pkg::flash_addr_t flash_address;
  logic                    flash_waitrequest;
  player_pkg::flash_word_t flash_readdata;
  logic                    flash_readdatavalid;
  player_pkg::sample_t     audio_sample;
  logic                    sample_valid;
  control_pkg::period_t    sample_period;
  logic                    playing;
  logic                    forward;
  int                      timeouts;
  int                      assert_fails;

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Eight-word song keeps the wrap points close
  ipod_top #(
    .repeat_cycles (40),
    .last_word     (23'd7)
  ) dut_i (.*);

  flash_model flash_model_i (.*);

  bind ipod_top ipod_properties #(.last_word(last_word)) props_i (.*);

  // ==================================================
  // Stimulus tasks
  // ==================================================

  task automatic idle(input int n);
    repeat (n) @(posedge CLK_50M);
  endtask

  task automatic send_code(input control_pkg::scan_code_t code);
    @(posedge CLK_50M);
    scan_code  <= code;
    scan_valid <= 1'b1;
    @(posedge CLK_50M);
    scan_valid <= 1'b0;
  endtask

  task automatic wait_samples(input int n);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < n && cycles < n * SAMPLE_LIMIT + 64)
    begin
      @(negedge CLK_50M);
      cycles++;
      if (sample_valid)
        seen++;
    end
    if (seen < n)
    begin
      timeouts++;
      $display("Timeout: only %0d of %0d samples arrived in %0d cycles", seen, n, cycles);
    end
  endtask

  // Holds one key until the period reaches target, then a while longer
  task automatic hold_key(input int idx, input control_pkg::period_t target, input int extra);
    int cycles;
    cycles = 0;
    @(posedge CLK_50M);
    key_n[idx] <= 1'b0;
    while (sample_period != target && cycles < KEY_LIMIT)
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    if (sample_period != target)
    begin
      timeouts++;
      $display("Timeout: period stuck at %0d, never reached %0d", sample_period, target);
    end
    idle(extra);
    key_n <= 3'b111;
    idle(4);
  endtask

  // ==================================================
  // Test sequence
  // ==================================================

  initial
  begin
    timeouts   = 0;
    rst        = 1'b1;
    scan_code  = '0;
    scan_valid = 1'b0;
    key_n      = 3'b111;
    idle(4);
    rst <= 1'b0;

    // Paused, ticks run but no samples
    idle(3 * control_pkg::PERIOD_DEFAULT);

    send_code(control_pkg::SCAN_PLAY);
    wait_samples(20);
    send_code(control_pkg::SCAN_BACKWARD);
    wait_samples(20);
    send_code(control_pkg::SCAN_PAUSE);
    idle(64);
    send_code(control_pkg::SCAN_RESTART);
    send_code(control_pkg::SCAN_PLAY);
    wait_samples(6);
    send_code(control_pkg::SCAN_FORWARD);
    wait_samples(6);
    send_code(control_pkg::SCAN_RESTART);
    wait_samples(6);
    send_code(control_pkg::SCAN_PAUSE);
    idle(64);
    send_code(8'h1C);

    // Speed keys while paused
    hold_key(control_pkg::KEY_FASTER, control_pkg::PERIOD_MIN, 160);
    hold_key(control_pkg::KEY_DEFAULT, control_pkg::PERIOD_DEFAULT, 8);
    hold_key(control_pkg::KEY_SLOWER, control_pkg::PERIOD_MAX, 160);
    hold_key(control_pkg::KEY_DEFAULT, control_pkg::PERIOD_DEFAULT, 8);
    hold_key(control_pkg::KEY_FASTER, 16'd1268, 0);

    // Faster playback
    send_code(control_pkg::SCAN_PLAY);
    wait_samples(10);
    send_code(control_pkg::SCAN_PAUSE);
    idle(64);

    assert_fails = dut_i.props_i.fail_count;
    $display("Errors: %0d assertion failures, %0d timeouts", assert_fails, timeouts);
    if (assert_fails == 0 && timeouts == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: files.f
logic/player_pkg.sv
logic/control_pkg.sv
logic/kbd_cmd_decoder.sv
logic/speed_control.sv
logic/sample_tick_gen.sv
logic/flash_reader.sv
logic/ipod_top.sv
dv/flash_model.sv
dv/ipod_properties.sv
dv/ipod_tb.sv

// File: Bender.yml
package:
  name: ipod_player

sources:
  - logic/player_pkg.sv
  - logic/control_pkg.sv
  - logic/kbd_cmd_decoder.sv
  - logic/speed_control.sv
  - logic/sample_tick_gen.sv
  - logic/flash_reader.sv
  - logic/ipod_top.sv
  - target: test
    files:
      - dv/flash_model.sv
      - dv/ipod_properties.sv
      - dv/ipod_tb.sv
